// ==== design/aluOpDecoder.sv ====
`timescale 1ns/1ps
`include "exec_consts.svh"

module aluOpDecoder
    import definitions::*;
(
    input  aluOp_t         aluOp,
    input  logic [6:0]     funct7,
    input  logic [2:0]     funct3,
    output aluOperation_t  opSel,
    output flag_t          error
);

    // funct7 groups
    localparam logic [6:0] f7Base   = 7'd0;
    localparam logic [6:0] f7MulDiv = 7'd1;
    localparam logic [6:0] f7Alt    = 7'd32;

    // base funct3 codes
    localparam logic [2:0] f3AddSub = 3'd0;
    localparam logic [2:0] f3Sll    = 3'd1;
    localparam logic [2:0] f3Slt    = 3'd2;
    localparam logic [2:0] f3Sltu   = 3'd3;
    localparam logic [2:0] f3Xor    = 3'd4;
    localparam logic [2:0] f3SrlSra = 3'd5;
    localparam logic [2:0] f3Or     = 3'd6;
    localparam logic [2:0] f3And    = 3'd7;

    // M extension funct3 codes
    localparam logic [2:0] f3Mul    = 3'd0;
    localparam logic [2:0] f3Mulh   = 3'd1;
    localparam logic [2:0] f3Mulhsu = 3'd2;
    localparam logic [2:0] f3Mulhu  = 3'd3;
    localparam logic [2:0] f3Div    = 3'd4;
    localparam logic [2:0] f3Divu   = 3'd5;
    localparam logic [2:0] f3Rem    = 3'd6;
    localparam logic [2:0] f3Remu   = 3'd7;

    always_comb begin
        opSel = ADD;
        error = LOW;
        case (aluOp)
            TYPE_I: begin
                // immediate shifts and SLTIU are not supported
                case (funct3)
                    f3AddSub: opSel = ADD;
                    f3Slt:    opSel = SLT;
                    f3Xor:    opSel = XOR;
                    f3Or:     opSel = OR;
                    f3And:    opSel = AND;
                    default: begin
                        opSel = ADD;
                        error = HIGH;
                    end
                endcase
            end
            TYPE_R: begin
                case (funct7)
                    f7Base: begin
                        case (funct3)
                            f3AddSub: opSel = ADD;
                            f3Sll:    opSel = SLL;
                            f3Slt:    opSel = SLT;
                            f3Sltu:   opSel = SLTU;
                            f3Xor:    opSel = XOR;
                            f3SrlSra: opSel = SRL;
                            f3Or:     opSel = OR;
                            f3And:    opSel = AND;
                        endcase
                    end
                    f7Alt: begin
                        case (funct3)
                            f3AddSub: opSel = SUB;
                            f3SrlSra: opSel = SRA;
                            default: begin
                                opSel = ADD;
                                error = HIGH;
                            end
                        endcase
                    end
                    f7MulDiv: begin
                        case (funct3)
                            f3Mul:    opSel = MUL;
                            f3Mulh:   opSel = MULH;
                            f3Mulhsu: opSel = MULHSU;
                            f3Mulhu:  opSel = MULHU;
                            f3Div:    opSel = DIV;
                            f3Divu:   opSel = DIVU;
                            f3Rem:    opSel = REM;
                            f3Remu:   opSel = REMU;
                        endcase
                    end
                    default: begin
                        opSel = ADD;
                        error = HIGH;
                    end
                endcase
            end
            DEF_ADD: opSel = ADD;
            PASS_S1: opSel = FWD;
        endcase
    end

endmodule

// ==== design/definitions.sv ====
package definitions;

    // decode class chosen from the opcode
    typedef enum logic [1:0] {
        TYPE_R,
        TYPE_I,
        DEF_ADD,
        PASS_S1
    } aluOp_t;

    // operations for the integer ALU and the M unit
    typedef enum logic [4:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, FWD,
        MUL, MULH, MULHSU, MULHU,
        DIV, DIVU, REM, REMU
    } aluOperation_t;

    typedef enum logic {
        LOW  = 1'b0,
        HIGH = 1'b1
    } flag_t;

    // one instruction word, seen as R-type or as I/U-type
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rType;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iuType;
    } instrWord_t;

    function automatic logic isMulDiv(aluOperation_t op);
        return op inside {MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU};
    endfunction

endpackage

// ==== design/exec_consts.svh ====
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// data path width
`define XLEN 32

// major opcodes handled by the execute stage
`define OPC_OP    7'b0110011
`define OPC_OPIMM 7'b0010011
`define OPC_LOAD  7'b0000011
`define OPC_LUI   7'b0110111

// one quotient bit per step
`define DIV_ITER 32

`endif

// ==== design/executeUnit.sv ====
`timescale 1ns/1ps
`include "exec_consts.svh"

module executeUnit
    import definitions::*;
(
    input  logic              clk,
    input  logic              arstN,
    input  logic              issue,
    input  instrWord_t        instr,
    input  logic [`XLEN-1:0]  rs1Val,
    input  logic [`XLEN-1:0]  rs2Val,
    output logic              busy,
    output logic              done,
    output logic [`XLEN-1:0]  result,
    output logic              illegal
);

    localparam logic [1:0] stIdle   = 2'd0;
    localparam logic [1:0] stDecode = 2'd1;
    localparam logic [1:0] stWaitM  = 2'd2;
    localparam logic [1:0] stFinish = 2'd3;

    logic [1:0] state;
    instrWord_t instrReg;
    logic [`XLEN-1:0] rs1Reg, rs2Reg, immVal, opA, opB, aluResult, mdResult;
    aluOp_t aluOp;
    aluOperation_t opSel;
    flag_t badOpcode, error;
    logic useImm, isIllegal, start, mdDone, issueOk;

    mainDecoder i_mainDecoder (
        .instr(instrReg), .aluOp(aluOp), .useImm(useImm), .immVal(immVal),
        .badOpcode(badOpcode)
    );

    aluOpDecoder i_aluOpDecoder (
        .aluOp(aluOp), .funct7(instrReg.rType.funct7), .funct3(instrReg.rType.funct3),
        .opSel(opSel), .error(error)
    );

    intAlu i_intAlu (.opSel(opSel), .opA(opA), .opB(opB), .aluResult(aluResult));

    mulDivUnit i_mulDivUnit (
        .clk(clk), .arstN(arstN), .start(start), .opSel(opSel), .opA(opA), .opB(opB),
        .mdDone(mdDone), .mdResult(mdResult)
    );

    // LUI forwards its immediate through opA
    assign opA       = (aluOp == PASS_S1) ? immVal : rs1Reg;
    assign opB       = useImm ? immVal : rs2Reg;
    assign isIllegal = (badOpcode == HIGH) || (error == HIGH);
    assign busy      = (state == stDecode) || (state == stWaitM);
    assign done      = (state == stFinish);
    assign issueOk   = issue && !busy;
    assign start     = (state == stDecode) && !isIllegal && isMulDiv(opSel);

    always_ff @(posedge clk) begin
        if (issueOk) begin
            instrReg <= instr;
            rs1Reg   <= rs1Val;
            rs2Reg   <= rs2Val;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state   <= stIdle;
            result  <= '0;
            illegal <= 1'b0;
        end else if (issueOk) begin
            state <= stDecode;
        end else begin
            case (state)
                stDecode: begin
                    if (isIllegal) begin
                        result  <= '0;
                        illegal <= 1'b1;
                        state   <= stFinish;
                    end else if (isMulDiv(opSel)) begin
                        state <= stWaitM;
                    end else begin
                        result  <= aluResult;
                        illegal <= 1'b0;
                        state   <= stFinish;
                    end
                end
                stWaitM: begin
                    if (mdDone) begin
                        result  <= mdResult;
                        illegal <= 1'b0;
                        state   <= stFinish;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    noIssueWhileBusy: assert property (@(posedge clk) disable iff (!arstN)
        issue |-> !busy)
        else $error("issue raised while the unit was busy");

    doneAfterBusy: assert property (@(posedge clk) disable iff (!arstN)
        done |-> $past(busy))
        else $error("done without a busy cycle before it");

    donePulse: assert property (@(posedge clk) disable iff (!arstN)
        done |=> !done)
        else $error("done held longer than one cycle");

endmodule

// ==== design/intAlu.sv ====
`timescale 1ns/1ps
`include "exec_consts.svh"

module intAlu
    import definitions::*;
(
    input  aluOperation_t     opSel,
    input  logic [`XLEN-1:0]  opA,
    input  logic [`XLEN-1:0]  opB,
    output logic [`XLEN-1:0]  aluResult
);

    logic [4:0] shamt;
    logic       ltSigned;
    logic       ltUnsigned;

    // only the low five bits count for RV32 shifts
    assign shamt      = opB[4:0];
    assign ltSigned   = $signed(opA) < $signed(opB);
    assign ltUnsigned = opA < opB;

    always_comb begin
        case (opSel)
            ADD:  aluResult = opA + opB;
            SUB:  aluResult = opA - opB;
            SLL:  aluResult = opA << shamt;
            SLT:  aluResult = {{(`XLEN-1){1'b0}}, ltSigned};
            SLTU: aluResult = {{(`XLEN-1){1'b0}}, ltUnsigned};
            XOR:  aluResult = opA ^ opB;
            SRL:  aluResult = opA >> shamt;
            SRA:  aluResult = $signed(opA) >>> shamt;
            OR:   aluResult = opA | opB;
            AND:  aluResult = opA & opB;
            FWD:  aluResult = opA;
            // M ops are served by mulDivUnit
            default: aluResult = '0;
        endcase
    end

endmodule

// ==== design/mainDecoder.sv ====
`timescale 1ns/1ps
`include "exec_consts.svh"

module mainDecoder
    import definitions::*;
(
    input  instrWord_t        instr,
    output aluOp_t            aluOp,
    output logic              useImm,
    output logic [`XLEN-1:0]  immVal,
    output flag_t             badOpcode
);

    logic [`XLEN-1:0] iImm;
    logic [`XLEN-1:0] uImm;

    // sign-extended I immediate
    assign iImm = {{(`XLEN-12){instr.iuType.imm[11]}}, instr.iuType.imm};
    // upper 20 bits, low 12 cleared
    assign uImm = {instr[31:12], 12'b0};

    always_comb begin
        aluOp     = TYPE_R;
        useImm    = 1'b0;
        immVal    = '0;
        badOpcode = LOW;
        case (instr.rType.opcode)
            `OPC_OP: begin
                aluOp = TYPE_R;
            end
            `OPC_OPIMM: begin
                aluOp  = TYPE_I;
                useImm = 1'b1;
                immVal = iImm;
            end
            `OPC_LOAD: begin
                // address add only
                aluOp  = DEF_ADD;
                useImm = 1'b1;
                immVal = iImm;
            end
            `OPC_LUI: begin
                // top level routes immVal into opA
                aluOp  = PASS_S1;
                immVal = uImm;
            end
            default: begin
                badOpcode = HIGH;
            end
        endcase
    end

endmodule

// ==== design/mulDivUnit.sv ====
`timescale 1ns/1ps
`include "exec_consts.svh"

module mulDivUnit
    import definitions::*;
(
    input  logic              clk,
    input  logic              arstN,
    input  logic              start,
    input  aluOperation_t     opSel,
    input  logic [`XLEN-1:0]  opA,
    input  logic [`XLEN-1:0]  opB,
    output logic              mdDone,
    output logic [`XLEN-1:0]  mdResult
);

    localparam int CntW = $clog2(`DIV_ITER + 1);

    logic isMul, signedDiv, remIn, divSpecial, overflow;
    logic signA, signB;
    logic signed [`XLEN:0] mulA, mulB;
    logic signed [2*`XLEN+1:0] product;
    logic [`XLEN-1:0] absA, absB;

    logic divBusy;
    logic [CntW-1:0] divCount;
    logic [`XLEN-1:0] divQuo, divRem, divisor;
    logic negQ, negR, wantRem;
    logic [`XLEN:0] shifted, trial;
    logic [`XLEN-1:0] stepQuo, stepRem;

    assign isMul     = opSel inside {MUL, MULH, MULHSU, MULHU};
    assign signedDiv = opSel inside {DIV, REM};
    assign remIn     = opSel inside {REM, REMU};

    // sign-aware 33-bit operands give all four products
    assign signA   = (opSel == MULH || opSel == MULHSU) && opA[`XLEN-1];
    assign signB   = (opSel == MULH) && opB[`XLEN-1];
    assign mulA    = {signA, opA};
    assign mulB    = {signB, opB};
    assign product = mulA * mulB;

    // most negative value divided by minus one
    assign overflow   = signedDiv && opA == {1'b1, {(`XLEN-1){1'b0}}} && opB == '1;
    assign divSpecial = (opB == '0) || overflow;
    assign absA = (signedDiv && opA[`XLEN-1]) ? -opA : opA;
    assign absB = (signedDiv && opB[`XLEN-1]) ? -opB : opB;

    // one restoring step
    assign shifted = {divRem, divQuo[`XLEN-1]};
    assign trial   = shifted - {1'b0, divisor};
    assign stepRem = trial[`XLEN] ? shifted[`XLEN-1:0] : trial[`XLEN-1:0];
    assign stepQuo = {divQuo[`XLEN-2:0], ~trial[`XLEN]};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mdDone   <= 1'b0;
            divBusy  <= 1'b0;
            divCount <= '0;
        end else begin
            mdDone <= 1'b0;
            if (start) begin
                if (isMul || divSpecial) begin
                    mdDone <= 1'b1;
                end else begin
                    divBusy  <= 1'b1;
                    divCount <= CntW'(`DIV_ITER);
                end
            end else if (divBusy) begin
                divCount <= divCount - 1'b1;
                if (divCount == 1) begin
                    divBusy <= 1'b0;
                    mdDone  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            if (isMul) begin
                mdResult <= (opSel == MUL) ? product[`XLEN-1:0] : product[2*`XLEN-1:`XLEN];
            end else if (opB == '0) begin
                mdResult <= remIn ? opA : '1;
            end else if (overflow) begin
                mdResult <= remIn ? '0 : opA;
            end else begin
                divQuo  <= absA;
                divRem  <= '0;
                divisor <= absB;
                negQ    <= signedDiv && (opA[`XLEN-1] ^ opB[`XLEN-1]);
                negR    <= signedDiv && opA[`XLEN-1];
                wantRem <= remIn;
            end
        end else if (divBusy) begin
            divQuo <= stepQuo;
            divRem <= stepRem;
            // last step, restore signs
            if (divCount == 1) begin
                if (wantRem) mdResult <= negR ? -stepRem : stepRem;
                else mdResult <= negQ ? -stepQuo : stepQuo;
            end
        end
    end

    startWhenIdle: assert property (@(posedge clk) disable iff (!arstN)
        start |-> !divBusy && isMulDiv(opSel))
        else $error("start while divide running or for a non-M operation");

    donePulse: assert property (@(posedge clk) disable iff (!arstN)
        mdDone |=> !mdDone)
        else $error("mdDone held longer than one cycle");

endmodule

// ==== dv/executeUnitTb.sv ====
`timescale 1ns/1ps
`include "exec_consts.svh"

module executeUnitTb;

    localparam int numInstr   = 112;
    localparam int cycleLimit = numInstr * (`DIV_ITER + 3) + 200;

    logic clk, arstN, issue, busy, done, illegal;
    logic [31:0] instr, rs1Val, rs2Val;
    logic [`XLEN-1:0] result;

    // expectations for the instruction in flight
    logic [31:0] expResult;
    logic expIllegal, awaiting;
    int expLatMin, expLatMax, issueCycle, cycleCnt;
    int failCount, instrCount, failsAtStart, instrAtStart, testsPassed, testsFailed;
    logic [31:0] cornerA [4];
    logic [31:0] cornerB [4];

    executeUnit i_executeUnit (
        .clk(clk), .arstN(arstN), .issue(issue), .instr(instr),
        .rs1Val(rs1Val), .rs2Val(rs2Val), .busy(busy), .done(done),
        .result(result), .illegal(illegal)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleCnt >= cycleLimit) begin
            $display("run stopped after %0d cycles, an instruction never finished", cycleCnt);
            $display("Verification failed");
            $finish;
        end
    end

    resultCheck: assert property (@(posedge clk) disable iff (!arstN) done |-> result == expResult)
        else begin
            failCount++;
            $display("[FAIL] result expected %h got %h", $sampled(expResult), $sampled(result));
        end

    illegalCheck: assert property (@(posedge clk) disable iff (!arstN)
        done |-> illegal == expIllegal)
        else begin
            failCount++;
            $display("[FAIL] illegal expected %h got %h", $sampled(expIllegal), $sampled(illegal));
        end

    latencyCheck: assert property (@(posedge clk) disable iff (!arstN)
        done |-> cycleCnt - issueCycle >= expLatMin && cycleCnt - issueCycle <= expLatMax)
        else begin
            failCount++;
            $display("done came %0d cycles after issue, allowed %0d to %0d",
                $sampled(cycleCnt) - $sampled(issueCycle), expLatMin, expLatMax);
        end

    busyHeld: assert property (@(posedge clk) disable iff (!arstN)
        awaiting && !issue && !done |-> busy)
        else begin
            failCount++;
            $display("busy went low before done");
        end

    doneExpected: assert property (@(posedge clk) disable iff (!arstN) done |-> awaiting)
        else begin
            failCount++;
            $display("done seen with no instruction outstanding");
        end

    donePulse: assert property (@(posedge clk) disable iff (!arstN) done |=> !done)
        else begin
            failCount++;
            $display("done stayed high for more than one cycle");
        end

    function automatic logic [31:0] rInstr(logic [6:0] f7, logic [2:0] f3, logic [6:0] op);
        return {f7, 5'd2, 5'd1, f3, 5'd3, op};
    endfunction

    function automatic logic [31:0] iInstr(logic [11:0] imm, logic [2:0] f3, logic [6:0] op);
        return {imm, 5'd1, f3, 5'd3, op};
    endfunction

    // RV32I base results, shared by OP and OP-IMM
    function automatic logic [31:0] baseOp(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            3'd0: return a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic predict(input logic [31:0] ins, input logic [31:0] a, input logic [31:0] b);
        logic [6:0] op;
        logic [6:0] f7;
        logic [2:0] f3;
        logic [31:0] imm;
        logic signed [63:0] sa, sb, ua, ub, prod;
        logic bad;
        op = ins[6:0];
        f3 = ins[14:12];
        f7 = ins[31:25];
        imm = {{20{ins[31]}}, ins[31:20]};
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'b0, a};
        ub = {32'b0, b};
        bad = 1'b0;
        expResult = '0;
        expLatMin = 2;
        expLatMax = 2;
        if (op == `OPC_OP && f7 == 7'd0) begin
            expResult = baseOp(f3, a, b);
        end else if (op == `OPC_OP && f7 == 7'd32 && f3 == 3'd0) begin
            expResult = a - b;
        end else if (op == `OPC_OP && f7 == 7'd32 && f3 == 3'd5) begin
            expResult = $signed(a) >>> b[4:0];
        end else if (op == `OPC_OP && f7 == 7'd1) begin
            expLatMin = 3;
            expLatMax = 3;
            if (!f3[2]) begin
                prod = (f3 == 3'd2) ? sa * ub : (f3 == 3'd3) ? ua * ub : sa * sb;
                expResult = (f3 == 3'd0) ? prod[31:0] : prod[63:32];
            end else if (b == '0) begin
                expResult = f3[1] ? a : 32'hffff_ffff;
            end else if (!f3[0] && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
                expResult = f3[1] ? 32'h0 : a;
            end else begin
                // iterative divide, length left to the DUT
                expLatMax = `DIV_ITER + 3;
                case (f3[1:0])
                    2'd0: expResult = $signed(a) / $signed(b);
                    2'd1: expResult = a / b;
                    2'd2: expResult = $signed(a) % $signed(b);
                    default: expResult = a % b;
                endcase
            end
        end else if (op == `OPC_OPIMM && f3 inside {3'd0, 3'd2, 3'd4, 3'd6, 3'd7}) begin
            expResult = baseOp(f3, a, imm);
        end else if (op == `OPC_LOAD) begin
            expResult = a + imm;
        end else if (op == `OPC_LUI) begin
            expResult = {ins[31:12], 12'b0};
        end else begin
            bad = 1'b1;
        end
        expIllegal = bad;
    endtask

    task automatic runInstr(input logic [31:0] ins, input logic [31:0] a, input logic [31:0] b);
        int waitCycles;
        @(negedge clk);
        predict(ins, a, b);
        instr = ins;
        rs1Val = a;
        rs2Val = b;
        issue = 1'b1;
        issueCycle = cycleCnt;
        awaiting = 1'b1;
        @(negedge clk);
        issue = 1'b0;
        waitCycles = 0;
        while (!done && waitCycles < `DIV_ITER + 8) begin
            @(negedge clk);
            waitCycles++;
        end
        if (!done) begin
            failCount++;
            $display("no done for instruction %h after %0d cycles", ins, waitCycles);
        end
        // let the checks at the done edge fire first
        @(negedge clk);
        awaiting = 1'b0;
        instrCount++;
    endtask

    task automatic finishTest(input int num, input string what);
        if (failCount == failsAtStart) testsPassed++;
        else testsFailed++;
        $display("test %0d %s: %0d instructions, %0d failures", num, what,
            instrCount - instrAtStart, failCount - failsAtStart);
        failsAtStart = failCount;
        instrAtStart = instrCount;
    endtask

    initial begin
        clk = 1'b0;
        arstN = 1'b0;
        issue = 1'b0;
        instr = '0;
        rs1Val = '0;
        rs2Val = '0;
        expResult = '0;
        expIllegal = 1'b0;
        awaiting = 1'b0;
        {expLatMin, expLatMax, issueCycle, cycleCnt} = '0;
        {failCount, instrCount, failsAtStart, instrAtStart, testsPassed, testsFailed} = '0;
        cornerA = '{32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
        cornerB = '{32'h8000_0000, 32'hffff_ffff, 32'hffff_ffff, 32'h8000_0000};
        void'($urandom(85711));
        repeat (10) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        @(negedge clk);
        resetResult: assert (result == '0)
            else begin
                failCount++;
                $display("[FAIL] result expected %h got %h", 32'h0, result);
            end
        resetFlags: assert (!busy && !done && !illegal)
            else begin
                failCount++;
                $display("busy, done or illegal not low after reset");
            end

        for (int rep = 0; rep < 2; rep++) begin
            for (int f3 = 0; f3 < 8; f3++) runInstr(rInstr(7'd0, f3, `OPC_OP), $urandom, $urandom);
            runInstr(rInstr(7'd32, 3'd0, `OPC_OP), $urandom, $urandom);
            runInstr(rInstr(7'd32, 3'd5, `OPC_OP), $urandom, $urandom);
        end
        finishTest(1, "reset and R-type base");

        for (int rep = 0; rep < 2; rep++)
            for (int f3 = 0; f3 < 8; f3++)
                runInstr(iInstr(12'($urandom), f3, `OPC_OPIMM), $urandom, $urandom);
        finishTest(2, "OP-IMM");

        foreach (cornerA[i]) begin
            runInstr(rInstr(7'd32, 3'd1 + 3'(i), `OPC_OP), $urandom, $urandom);
        end
        runInstr(rInstr(7'd32, 3'd6, `OPC_OP), $urandom, $urandom);
        runInstr(rInstr(7'd32, 3'd7, `OPC_OP), $urandom, $urandom);
        runInstr(rInstr(7'h02, 3'($urandom), `OPC_OP), $urandom, $urandom);
        runInstr(rInstr(7'h40, 3'($urandom), `OPC_OP), $urandom, $urandom);
        runInstr(rInstr(7'h7f, 3'($urandom), `OPC_OP), $urandom, $urandom);
        // branch, store and an unused opcode
        runInstr(rInstr(7'd0, 3'd0, 7'b1100011), $urandom, $urandom);
        runInstr(rInstr(7'd0, 3'd2, 7'b0100011), $urandom, $urandom);
        runInstr(rInstr(7'd0, 3'd0, 7'b1111111), $urandom, $urandom);
        finishTest(3, "illegal encodings");

        repeat (4) runInstr(iInstr(12'($urandom), 3'd2, `OPC_LOAD), $urandom, $urandom);
        repeat (4) runInstr({20'($urandom), 5'd3, `OPC_LUI}, $urandom, $urandom);
        finishTest(4, "LOAD and LUI");

        for (int f3 = 0; f3 < 4; f3++) begin
            repeat (4) runInstr(rInstr(7'd1, f3, `OPC_OP), $urandom, $urandom);
            foreach (cornerA[i]) runInstr(rInstr(7'd1, f3, `OPC_OP), cornerA[i], cornerB[i]);
        end
        finishTest(5, "multiply");

        for (int f3 = 4; f3 < 8; f3++) begin
            repeat (4) runInstr(rInstr(7'd1, f3, `OPC_OP), $urandom, $urandom >> ($urandom % 32));
            runInstr(rInstr(7'd1, f3, `OPC_OP), $urandom, 32'h0);
            runInstr(rInstr(7'd1, f3, `OPC_OP), 32'h8000_0000, 32'hffff_ffff);
        end
        finishTest(6, "divide and remainder");

        $display("tests passed: %0d, tests failed: %0d", testsPassed, testsFailed);
        if (failCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+design
design/definitions.sv
design/mainDecoder.sv
design/aluOpDecoder.sv
design/intAlu.sv
design/mulDivUnit.sv
design/executeUnit.sv
dv/executeUnitTb.sv
